// File: compile.f
fft_num_pkg.sv
fft_sched_pkg.sv
fft_sample_collector.sv
fft_butterfly.sv
fft_core.sv
fft_out_seq.sv
fft_top.sv
fft_out_chk.sv
tb_fft.sv

// File: tb_fft.sv
`timescale 1ns/10ps

module tb_fft
    import fft_num_pkg::*;
();

    localparam int n_frames       = 14;
    localparam int timeout_cycles = n_frames * n_points * 2 + 400;

    logic        clk;
    logic        rst;
    sample_t     fir_d;
    logic        fir_valid;
    frame_t      fft_d;
    logic        fft_valid;
    logic        done;
    logic [31:0] lfsr_state;
    spectrum_t   exp_q [$];
    int          accept_q [$];
    int          cyc = 0;
    int          done_seen = 0;
    logic        stream_over;
    logic        prev_fv;
    logic        prev_ffv;
    logic        drain_pending;
    logic        done_next;
    int          vrun;
    int          in_cnt;
    spectrum_t   cur;

    fft_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .fir_d     (fir_d),
        .fir_valid (fir_valid),
        .fft_d     (fft_d),
        .fft_valid (fft_valid),
        .done      (done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc++;
        if (cyc > timeout_cycles) begin
            $display("timeout: stream not finished after %0d cycles", timeout_cycles);
            $display("Simulation failed");
            $fatal(1);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic frame_t random_frame();
        frame_t x;
        for (int n = 0; n < n_points; n++) x[n] = sample_t'(rand_bits(16));
        return x;
    endfunction

    // radix-2 dif, 8 fraction bits inside, twiddle products cut to [47:16]
    function automatic spectrum_t ref_fft(input frame_t x);
        acc_t               re [n_points];
        acc_t               im [n_points];
        acc_t               dr;
        acc_t               di;
        sample_t            xs;
        logic signed [63:0] p_rr;
        logic signed [63:0] p_ii;
        logic signed [63:0] p_ri;
        logic signed [63:0] p_ir;
        logic [3:0]         kk;
        logic [3:0]         rev;
        int                 half;
        int                 a;
        int                 b;
        int                 k;
        spectrum_t          res;
        for (int n = 0; n < n_points; n++) begin
            xs = x[n];
            re[n] = acc_t'(xs) * 256;
            im[n] = '0;
        end
        for (int s = 0; s < n_stages; s++) begin
            half = n_points >> (s + 1);
            for (int g = 0; g < n_points; g += 2 * half) begin
                for (int j = 0; j < half; j++) begin
                    a = g + j;
                    b = a + half;
                    k = j << s;
                    dr = re[a] - re[b];
                    di = im[a] - im[b];
                    re[a] = re[a] + re[b];
                    im[a] = im[a] + im[b];
                    p_rr = longint'(dr) * longint'(w_re[k]);
                    p_ii = -(longint'(di) * longint'(w_im[k]));
                    p_ri = longint'(dr) * longint'(w_im[k]);
                    p_ir = longint'(di) * longint'(w_re[k]);
                    re[b] = p_rr[47:16] + p_ii[47:16];
                    im[b] = p_ri[47:16] + p_ir[47:16];
                end
            end
        end
        for (int n = 0; n < n_points; n++) begin
            kk = 4'(n);
            rev = {kk[0], kk[1], kk[2], kk[3]};
            res.re[n] = re[rev][23:8];
            res.im[n] = im[rev][23:8];
        end
        return res;
    endfunction

    task automatic report_error(input string msg);
        $display("ERR %0t: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_frame(input frame_t got, input frame_t exp, input string label);
        int bad;
        bad = -1;
        for (int k = 0; k < n_points; k++) begin
            if (bad < 0 && got[k] !== exp[k]) bad = k;
        end
        if (bad >= 0) begin
            report_error($sformatf("%s bin %0d is %0d, expected %0d",
                                   label, bad, got[bad], exp[bad]));
        end
    endtask

    task automatic check_done(input logic got, input logic exp);
        if (got !== exp) report_error($sformatf("done is %b, expected %b", got, exp));
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp) report_error($sformatf("latency %0d edges, expected %0d", got, exp));
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            fir_valid = 1'b0;
            fir_d     = sample_t'(rand_bits(16));
        end
    endtask

    task automatic send_frame(input frame_t x, input spectrum_t exp, input logic gaps);
        for (int n = 0; n < n_points; n++) begin
            if (gaps && rand_bits(2) == 0) idle_cycles(1 + int'(rand_bits(2)));
            @(posedge clk);
            #1;
            fir_valid = 1'b1;
            fir_d     = x[n];
        end
        exp_q.push_back(exp);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // output monitor
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (rst) begin
            check_done(done, 1'b0);
            if (fft_valid) report_error("fft_valid high during reset");
            prev_fv       = 1'b0;
            prev_ffv      = 1'b0;
            drain_pending = 1'b0;
            done_next     = 1'b0;
            vrun          = 0;
            in_cnt        = 0;
        end else begin
            check_done(done, done_next);
            if (done && fft_valid) report_error("done overlaps fft_valid");
            if (done && stream_over) done_seen++;
            // done follows the end of an output pair once the input has stopped
            done_next = drain_pending && prev_ffv && !fft_valid && !fir_valid;
            if (fir_valid || done_next) begin
                drain_pending = 1'b0;
            end else if (prev_fv) begin
                drain_pending = 1'b1;
            end
            if (fir_valid) begin
                in_cnt++;
                if (in_cnt == n_points) begin
                    accept_q.push_back(cyc + 1);
                    in_cnt = 0;
                end
            end
            if (fft_valid) begin
                vrun++;
                if (vrun == 1) begin
                    if (exp_q.size() == 0 || accept_q.size() == 0) begin
                        report_error("fft_valid with no frame outstanding");
                    end else begin
                        cur = exp_q.pop_front();
                        check_latency(cyc - accept_q.pop_front(), 6);
                        check_frame(fft_d, cur.re, "real");
                    end
                end else if (vrun == 2) begin
                    check_frame(fft_d, cur.im, "imag");
                end else begin
                    report_error("fft_valid held longer than two cycles");
                end
            end else begin
                if (vrun == 1) report_error("fft_valid lasted only one cycle");
                vrun = 0;
            end
            prev_fv  = fir_valid;
            prev_ffv = fft_valid;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        frame_t    x;
        spectrum_t e;
        spectrum_t r;
        lfsr_state  = 32'hcf6e5409;
        rst         = 1'b1;
        fir_valid   = 1'b0;
        fir_d       = '0;
        stream_over = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        idle_cycles(6);

        // an impulse gives a flat real spectrum
        x = '0;
        x[0] = 16'sd1000;
        e = '0;
        for (int n = 0; n < n_points; n++) e.re[n] = 16'sd1000;
        r = ref_fft(x);
        check_frame(r.re, e.re, "impulse reference real");
        check_frame(r.im, e.im, "impulse reference imag");
        send_frame(x, e, 1'b0);

        // a constant lands entirely in bin 0
        for (int n = 0; n < n_points; n++) x[n] = 16'sd100;
        e = '0;
        e.re[0] = 16'sd1600;
        r = ref_fft(x);
        check_frame(r.re, e.re, "constant reference real");
        check_frame(r.im, e.im, "constant reference imag");
        send_frame(x, e, 1'b0);

        repeat (6) begin
            x = random_frame();
            send_frame(x, ref_fft(x), 1'b1);
        end
        repeat (n_frames - 8) begin
            x = random_frame();
            send_frame(x, ref_fft(x), 1'b0);
        end

        idle_cycles(1);
        stream_over = 1'b1;
        wait (done_seen > 0);
        repeat (10) @(posedge clk);
        if (done_seen == 1 && exp_q.size() == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("end of run: %0d frames unchecked, %0d done pulses",
                     exp_q.size(), done_seen);
            $display("Simulation failed");
            $fatal(1);
        end
    end

endmodule

// File: fft_out_chk.sv
`timescale 1ns/10ps

module fft_out_chk
    import fft_num_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input spectrum_t spec,
    input logic      result_valid,
    input frame_t    fft_d,
    input logic      fft_valid,
    input logic      done
);

    // real cycle then imaginary cycle and then low
    a_pair_len: assert property (@(posedge clk) disable iff (rst)
        $rose(fft_valid) |=> fft_valid ##1 !fft_valid)
        else $error("fft_valid did not last exactly two cycles");

    a_done_alone: assert property (@(posedge clk) disable iff (rst)
        !(done && fft_valid))
        else $error("done asserted together with fft_valid");

    // a result leaves as its real frame and then its imaginary frame
    a_result_to_out: assert property (@(posedge clk) disable iff (rst)
        result_valid |=> (fft_valid && fft_d == $past(spec.re))
                         ##1 (fft_valid && fft_d == $past(spec.im, 2)))
        else $error("result_valid not followed by its real and imaginary frames");

endmodule

bind fft_out_seq fft_out_chk u_out_chk (
    .clk          (clk),
    .rst          (rst),
    .spec         (spec),
    .result_valid (result_valid),
    .fft_d        (fft_d),
    .fft_valid    (fft_valid),
    .done         (done)
);

// File: fft_top.sv
`timescale 1ns/10ps

module fft_top
    import fft_num_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  sample_t fir_d,
    input  logic    fir_valid,
    output frame_t  fft_d,
    output logic    fft_valid,
    output logic    done
);

    block_t    block;
    logic      frame_ready;
    spectrum_t spec;
    logic      result_valid;

    fft_sample_collector u_collector (
        .clk         (clk),
        .rst         (rst),
        .fir_d       (fir_d),
        .fir_valid   (fir_valid),
        .block       (block),
        .frame_ready (frame_ready)
    );

    fft_core u_core (
        .clk          (clk),
        .rst          (rst),
        .block        (block),
        .frame_ready  (frame_ready),
        .spec         (spec),
        .result_valid (result_valid)
    );

    fft_out_seq u_out_seq (
        .clk          (clk),
        .rst          (rst),
        .spec         (spec),
        .result_valid (result_valid),
        .fir_valid    (fir_valid),
        .fft_d        (fft_d),
        .fft_valid    (fft_valid),
        .done         (done)
    );

endmodule

// File: fft_out_seq.sv
`timescale 1ns/10ps

module fft_out_seq
    import fft_num_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  spectrum_t spec,
    input  logic      result_valid,
    input  logic      fir_valid,
    output frame_t    fft_d,
    output logic      fft_valid,
    output logic      done
);

    logic imag_sel;
    logic fir_valid_d;
    logic fft_valid_d;
    logic wait_drain;
    logic in_end;
    logic out_end;

    ////////////////////////////////////////////////////////////////////////////
    // frame presentation
    ////////////////////////////////////////////////////////////////////////////

    // real on the result cycle, imaginary right after
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            imag_sel  <= 1'b0;
            fft_valid <= 1'b0;
        end else begin
            imag_sel  <= result_valid;
            fft_valid <= result_valid | imag_sel;
        end
    end

    always_ff @(posedge clk) begin
        if (result_valid || imag_sel) begin
            fft_d <= imag_sel ? spec.im : spec.re;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // end of stream
    ////////////////////////////////////////////////////////////////////////////

    assign in_end  = fir_valid_d & ~fir_valid;
    assign out_end = fft_valid_d & ~fft_valid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fir_valid_d <= 1'b0;
            fft_valid_d <= 1'b0;
            wait_drain  <= 1'b0;
            done        <= 1'b0;
        end else begin
            fir_valid_d <= fir_valid;
            fft_valid_d <= fft_valid;
            done        <= wait_drain & out_end & ~fir_valid;
            // input resuming means the stream is still going
            if (fir_valid || (wait_drain && out_end)) begin
                wait_drain <= 1'b0;
            end else if (in_end) begin
                wait_drain <= 1'b1;
            end
        end
    end

endmodule

// File: fft_core.sv
`timescale 1ns/10ps

module fft_core
    import fft_num_pkg::*;
    import fft_sched_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  block_t    block,
    input  logic      frame_ready,
    output spectrum_t spec,
    output logic      result_valid
);

    stage_e     state;
    stage_e     phase;
    stage_e     next_state;
    logic [1:0] s_idx;
    logic       rd_b;
    block_t     buf_a;
    block_t     buf_b;
    block_t     src;
    block_t     stage_out;
    logic [3:0] idx_a [n_bfly];
    logic [3:0] idx_b [n_bfly];
    cplx_t      y_a   [n_bfly];
    cplx_t      y_b   [n_bfly];

    ////////////////////////////////////////////////////////////////////////////
    // sequencing
    ////////////////////////////////////////////////////////////////////////////

    // a new block only shows up while idle, load wins over the register
    assign phase = frame_ready ? st_load : state;

    always_comb begin
        case (phase)
            st_load: next_state = st_s1;
            st_s1:   next_state = st_s2;
            st_s2:   next_state = st_s3;
            st_s3:   next_state = st_s4;
            st_s4:   next_state = st_result;
            default: next_state = st_idle;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    assign result_valid = (state == st_result);

    ////////////////////////////////////////////////////////////////////////////
    // butterfly array
    ////////////////////////////////////////////////////////////////////////////

    assign s_idx = 2'(state - st_s1);
    // odd stages read a, even stages read b
    assign rd_b  = (state == st_s2) || (state == st_s4);
    assign src   = rd_b ? buf_b : buf_a;

    for (genvar i = 0; i < n_bfly; i++) begin : g_bfly
        logic [2:0] iw;

        assign idx_a[i] = pair_a(3'(i), s_idx);
        assign idx_b[i] = pair_b(3'(i), s_idx);
        assign iw       = twiddle_idx(3'(i), s_idx);

        fft_butterfly u_bfly (
            .a       (src[idx_a[i]]),
            .b       (src[idx_b[i]]),
            .w_re_in (w_re[iw]),
            .w_im_in (w_im[iw]),
            .y_a     (y_a[i]),
            .y_b     (y_b[i])
        );
    end

    // in place, results go back to their operand slots
    always_comb begin
        stage_out = src;
        for (int i = 0; i < n_bfly; i++) begin
            stage_out[idx_a[i]] = y_a[i];
            stage_out[idx_b[i]] = y_b[i];
        end
    end

    always_ff @(posedge clk) begin
        case (phase)
            st_load:      buf_a <= block;
            st_s1, st_s3: buf_b <= stage_out;
            st_s2, st_s4: buf_a <= stage_out;
            default: ;
        endcase
    end

    // dif leaves bins bit reversed in buf_a
    always_comb begin
        for (int k = 0; k < n_points; k++) begin
            spec.re[k] = buf_a[bit_rev4(4'(k))].re[23:8];
            spec.im[k] = buf_a[bit_rev4(4'(k))].im[23:8];
        end
    end

endmodule

// File: fft_butterfly.sv
`timescale 1ns/10ps

module fft_butterfly
    import fft_num_pkg::*;
(
    input  cplx_t a,
    input  cplx_t b,
    input  coef_t w_re_in,
    input  coef_t w_im_in,
    output cplx_t y_a,
    output cplx_t y_b
);

    acc_t               d_re;
    acc_t               d_im;
    logic signed [63:0] p_rr;
    logic signed [63:0] p_ii;
    logic signed [63:0] p_ri;
    logic signed [63:0] p_ir;

    assign d_re = a.re - b.re;
    assign d_im = a.im - b.im;

    // (d_re + j*d_im) * (w_re + j*w_im)
    assign p_rr = d_re * w_re_in;
    assign p_ii = -d_im * w_im_in;
    assign p_ri = d_re * w_im_in;
    assign p_ir = d_im * w_re_in;

    assign y_a.re = a.re + b.re;
    assign y_a.im = a.im + b.im;

    // drop the 16 twiddle fraction bits before summing
    assign y_b.re = p_rr[47:16] + p_ii[47:16];
    assign y_b.im = p_ri[47:16] + p_ir[47:16];

endmodule

// File: fft_sample_collector.sv
`timescale 1ns/10ps

module fft_sample_collector
    import fft_num_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  sample_t fir_d,
    input  logic    fir_valid,
    output block_t  block,
    output logic    frame_ready
);

    logic [3:0] cnt;
    acc_t       widened;

    // sign extend, sample in the middle, 8 fraction bits
    assign widened = {{8{fir_d[15]}}, fir_d, 8'd0};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt         <= 4'd0;
            frame_ready <= 1'b0;
        end else if (fir_valid) begin
            frame_ready <= (cnt == 4'(n_points - 1));
            // wraps to zero after the last entry
            cnt         <= cnt + 4'd1;
        end else begin
            frame_ready <= 1'b0;
        end
    end

    // real input only
    always_ff @(posedge clk) begin
        if (fir_valid) begin
            block[cnt] <= '{re: widened, im: '0};
        end
    end

endmodule

// File: fft_sched_pkg.sv
package fft_sched_pkg;

    import fft_num_pkg::*;

    // stage codes are the stage number plus one
    typedef enum logic [2:0] {
        st_idle   = 3'd0,
        st_s1     = 3'd1,
        st_s2     = 3'd2,
        st_s3     = 3'd3,
        st_s4     = 3'd4,
        st_load   = 3'd5,
        st_result = 3'd7
    } stage_e;

    // distance between the two butterfly legs at stage s
    function automatic int half_span(input logic [1:0] s);
        return (n_points / 2) >> s;
    endfunction

    function automatic logic [3:0] pair_a(input logic [2:0] i, input logic [1:0] s);
        int half;
        half = half_span(s);
        return 4'((i / half) * 2 * half + (i % half));
    endfunction

    function automatic logic [3:0] pair_b(input logic [2:0] i, input logic [1:0] s);
        return pair_a(i, s) + 4'(half_span(s));
    endfunction

    function automatic logic [2:0] twiddle_idx(input logic [2:0] i, input logic [1:0] s);
        return 3'((i % half_span(s)) << s);
    endfunction

    function automatic logic [3:0] bit_rev4(input logic [3:0] x);
        logic [3:0] r;
        for (int k = 0; k < n_stages; k++) r[k] = x[n_stages-1-k];
        return r;
    endfunction

endpackage

// File: fft_num_pkg.sv
package fft_num_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // transform geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int n_points = 16;
    localparam int n_stages = 4;
    localparam int n_bfly   = n_points / 2;

    ////////////////////////////////////////////////////////////////////////////
    // number formats
    ////////////////////////////////////////////////////////////////////////////

    // raw input sample, also one part of an output bin
    typedef logic signed [15:0] sample_t;

    // 8 fraction bits, sample lives in [23:8]
    typedef logic signed [31:0] acc_t;

    // 16 fraction bits
    typedef logic signed [31:0] coef_t;

    typedef struct packed {
        acc_t re;
        acc_t im;
    } cplx_t;

    typedef cplx_t [n_points-1:0] block_t;

    typedef sample_t [n_points-1:0] frame_t;

    // natural bin order
    typedef struct packed {
        frame_t re;
        frame_t im;
    } spectrum_t;

    ////////////////////////////////////////////////////////////////////////////
    // twiddles, w^k = cos(2*pi*k/16) - j*sin(2*pi*k/16)
    ////////////////////////////////////////////////////////////////////////////

    localparam coef_t w_re [0:7] = '{
        32'sh00010000, 32'sh0000ec83, 32'sh0000b504, 32'sh000061f7,
        32'sh00000000, 32'shffff9e09, 32'shffff4afc, 32'shffff137d
    };

    localparam coef_t w_im [0:7] = '{
        32'sh00000000, 32'shffff9e09, 32'shffff4afc, 32'shffff137d,
        32'shffff0000, 32'shffff137d, 32'shffff4afc, 32'shffff9e09
    };

endpackage
